//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f board_game.f --top-module board_game_tb \
		-Mdir obj_dir -o board_game_sim

run: compile
	./obj_dir/board_game_sim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- board_game.f
hw/board_game_pkg.sv
hw/cursor_pacer.sv
hw/game_control.sv
hw/move_checker.sv
hw/board_memory.sv
hw/board_game_top.sv
dv/clock_gen.sv
dv/board_game_properties.sv
dv/board_game_tb.sv

//--- dv/board_game_properties.sv
`default_nettype none

module board_game_properties #(
  parameter int BOARD_SIZE = 8
) (
  input logic                        clk,
  input logic                        reset,
  input logic                        select,
  input logic                        game_over,
  input logic                        winner,
  input board_game_pkg::game_state_t state,
  input board_game_pkg::mem_op_t     mem_op,
  input board_game_pkg::coord_t      box_x,
  input board_game_pkg::coord_t      box_y
);

  timeunit 1ns;
  timeprecision 100ps;

  import board_game_pkg::*;

  box_on_board: assert property (@(posedge clk) disable iff (reset)
    (box_x < BOARD_SIZE) && (box_y < BOARD_SIZE))
    else $error("selection box left the board");

  // result is sticky until reset
  result_sticky: assert property (@(posedge clk) disable iff (reset)
    game_over |=> game_over && $stable(winner))
    else $error("game_over or winner changed before reset");

  move_in_commit: assert property (@(posedge clk) disable iff (reset)
    (mem_op == MEM_MOVE) |-> (state == S_COMMIT_MOVE))
    else $error("board write outside the commit state");

  wait_release: assert property (@(posedge clk) disable iff (reset)
    (state == S_VALIDATE_PIECE && select) |=> (state == S_VALIDATE_PIECE))
    else $error("piece validation left while select was held");

endmodule

bind game_control board_game_properties #(
  .BOARD_SIZE (BOARD_SIZE)
) i_properties (
  .clk       (clk),
  .reset     (reset),
  .select    (select),
  .game_over (game_over),
  .winner    (winner),
  .state     (state),
  .mem_op    (mem_op),
  .box_x     (dst_x),
  .box_y     (dst_y)
);

`default_nettype wire

//--- dv/board_game_tb.sv
`default_nettype none

module board_game_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import board_game_pkg::*;

  typedef struct packed {
    logic [3:0] sx;
    logic [3:0] sy;
    logic [3:0] dx;
    logic [3:0] dy;
    logic       desel;
    logic       accept;
  } row_t;

  localparam int NUM_ROWS = 16;

  // source, destination, deselect, expected accept
  localparam row_t ROWS [NUM_ROWS] = '{
    '{4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 1'b0},
    '{4'd0, 4'd6, 4'd0, 4'd0, 1'b0, 1'b0},
    '{4'd2, 4'd1, 4'd0, 4'd0, 1'b1, 1'b0},
    '{4'd2, 4'd1, 4'd2, 4'd3, 1'b0, 1'b0},
    '{4'd2, 4'd1, 4'd3, 4'd1, 1'b0, 1'b0},
    '{4'd4, 4'd1, 4'd4, 4'd2, 1'b0, 1'b1},
    '{4'd3, 4'd6, 4'd3, 4'd5, 1'b0, 1'b1},
    '{4'd4, 4'd2, 4'd4, 4'd3, 1'b0, 1'b1},
    '{4'd3, 4'd5, 4'd3, 4'd4, 1'b0, 1'b1},
    '{4'd4, 4'd3, 4'd3, 4'd4, 1'b0, 1'b1},
    '{4'd4, 4'd6, 4'd4, 4'd5, 1'b0, 1'b1},
    '{4'd3, 4'd4, 4'd4, 4'd5, 1'b0, 1'b1},
    '{4'd5, 4'd6, 4'd5, 4'd5, 1'b0, 1'b1},
    '{4'd4, 4'd5, 4'd4, 4'd6, 1'b0, 1'b1},
    '{4'd5, 4'd5, 4'd5, 4'd4, 1'b0, 1'b1},
    '{4'd4, 4'd6, 4'd4, 4'd7, 1'b0, 1'b1}
  };

  logic   clk;
  logic   reset;
  logic   reset_req;
  logic   up;
  logic   down;
  logic   left;
  logic   right;
  logic   select;
  logic   deselect;
  coord_t view_x;
  coord_t view_y;
  piece_t view_piece;
  coord_t box_x;
  coord_t box_y;
  logic   current_player;
  logic   game_over;
  logic   winner;

  // reference board and box
  piece_t model [8][8];
  int     box_mx;
  int     box_my;
  logic   player_m;

  clock_gen i_clock (
    .reset_req (reset_req),
    .clk       (clk),
    .reset     (reset)
  );

  board_game_top #(
    .BOARD_SIZE (8),
    .PACE_DIV   (1)
  ) i_dut (
    .clk            (clk),
    .reset          (reset),
    .up             (up),
    .down           (down),
    .left           (left),
    .right          (right),
    .select         (select),
    .deselect       (deselect),
    .view_x         (view_x),
    .view_y         (view_y),
    .view_piece     (view_piece),
    .box_x          (box_x),
    .box_y          (box_y),
    .current_player (current_player),
    .game_over      (game_over),
    .winner         (winner)
  );

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    $display("%0t ns: %s", $time, msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else report_mismatch(name, got, exp);
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_state(input game_state_t s);
    int n;
    n = 0;
    while (i_dut.i_control.state != s) begin
      tick();
      n++;
      if (n > 20) begin
        report_failure("timed out waiting for the control FSM state");
      end
    end
  endtask

  // king in the middle of each back row, soldiers in front
  task automatic init_model();
    for (int x = 0; x < 8; x++) begin
      for (int y = 0; y < 8; y++) begin
        model[x][y] = 4'h0;
      end
      model[x][1] = 4'h1;
      model[x][6] = 4'h9;
    end
    model[4][0] = 4'h2;
    model[4][7] = 4'hA;
    box_mx = 0;
    box_my = 0;
    player_m = 1'b0;
  endtask

  // view port is combinational, so the whole scan fits in one cycle
  task automatic compare_board();
    for (int x = 0; x < 8; x++) begin
      for (int y = 0; y < 8; y++) begin
        view_x = coord_t'(x);
        view_y = coord_t'(y);
        #0.2;
        check_val($sformatf("view_piece(%0d,%0d)", x, y), view_piece, model[x][y]);
      end
    end
    tick();
  endtask

  task automatic check_box();
    check_val("box_x", box_x, box_mx);
    check_val("box_y", box_y, box_my);
  endtask

  task automatic steer_to(input int x, input int y);
    while (box_mx != x || box_my != y) begin
      right = (box_mx < x);
      left  = (box_mx > x);
      up    = (box_my < y);
      down  = (box_my > y);
      tick();
      box_mx = box_mx + (right ? 1 : 0) - (left ? 1 : 0);
      box_my = box_my + (up ? 1 : 0) - (down ? 1 : 0);
      {right, left, up, down} = 4'b0;
      tick();
    end
    check_box();
  endtask

  // held into the validate state so the FSM has to wait for the release
  task automatic press_select();
    select = 1'b1;
    repeat (3) tick();
    select = 1'b0;
  endtask

  task automatic press_deselect();
    deselect = 1'b1;
    wait_state(S_MOVE_BOX_1);
    deselect = 1'b0;
  endtask

  task automatic check_edges();
    left = 1'b1;
    down = 1'b1;
    repeat (3) tick();
    {left, down} = 2'b0;
    check_box();
    right = 1'b1;
    up    = 1'b1;
    repeat (10) tick();
    {right, up} = 2'b0;
    box_mx = 7;
    box_my = 7;
    check_box();
    steer_to(0, 0);
  endtask

  task automatic run_row(input row_t r);
    piece_t sp;
    piece_t dp;
    logic   pok;
    logic   mok;
    logic   king;
    logic   mover;
    int     dxd;
    int     dyd;
    int     n;
    steer_to(r.sx, r.sy);
    press_select();
    sp  = model[r.sx][r.sy];
    pok = (sp[2:0] != 3'd0) && (sp[3] == player_m);
    if (!pok) begin
      check_val("table accept", r.accept, 0);
      wait_state(S_MOVE_BOX_1);
      check_val("current_player", current_player, player_m);
      compare_board();
      return;
    end
    wait_state(S_MOVE_BOX_2);
    if (r.desel) begin
      press_deselect();
      compare_board();
      return;
    end
    steer_to(r.dx, r.dy);
    press_select();
    dp  = model[r.dx][r.dy];
    dxd = (r.dx > r.sx) ? r.dx - r.sx : r.sx - r.dx;
    dyd = (r.dy > r.sy) ? r.dy - r.sy : r.sy - r.dy;
    mok = (dxd <= 1) && (dyd <= 1) && (dxd + dyd != 0) &&
          ((dp[2:0] == 3'd0) || (dp[3] != player_m));
    check_val("table accept", r.accept, mok);
    if (!mok) begin
      wait_state(S_MOVE_BOX_2);
      check_val("current_player", current_player, player_m);
      press_deselect();
      compare_board();
      return;
    end
    king  = (dp[2:0] == 3'd2) && (dp[3] != player_m);
    mover = player_m;
    n = 0;
    while (current_player == player_m) begin
      tick();
      n++;
      if (n > 8) begin
        report_failure("current_player did not toggle after an accepted move");
      end
    end
    check_val("move latency", n, 2);
    model[r.dx][r.dy] = sp;
    model[r.sx][r.sy] = 4'h0;
    player_m = ~player_m;
    if (king) begin
      n = 0;
      while (!game_over) begin
        tick();
        n++;
        if (n > 8) begin
          report_failure("game_over did not rise after a king capture");
        end
      end
      check_val("game_over latency", n, 1);
      check_val("winner", winner, mover);
    end else begin
      wait_state(S_MOVE_BOX_1);
    end
    compare_board();
  endtask

  task automatic check_start();
    int n;
    n = 0;
    while (reset) begin
      tick();
      n++;
      if (n > 30) begin
        report_failure("reset never released");
      end
    end
    wait_state(S_MOVE_BOX_1);
    init_model();
    check_box();
    check_val("current_player", current_player, 0);
    check_val("game_over", game_over, 0);
    check_val("winner", winner, 0);
    compare_board();
  endtask

  initial begin
    {up, down, left, right} = 4'b0;
    select    = 1'b0;
    deselect  = 1'b0;
    reset_req = 1'b0;
    view_x    = '0;
    view_y    = '0;
    tick();
    check_start();
    check_edges();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(ROWS[i]);
    end
    // after the game ends every button is ignored
    up = 1'b1;
    right = 1'b1;
    select = 1'b1;
    repeat (3) tick();
    {up, right, select} = 3'b0;
    deselect = 1'b1;
    tick();
    deselect = 1'b0;
    tick();
    check_box();
    check_val("game_over", game_over, 1);
    check_val("winner", winner, 0);
    check_val("current_player", current_player, player_m);
    compare_board();
    reset_req = 1'b1;
    tick();
    reset_req = 1'b0;
    tick();
    check_start();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/clock_gen.sv
`default_nettype none

module clock_gen (
  input  logic reset_req,
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned rst_cnt = 8;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // eight cycles of reset at start and on each request
  always @(posedge clk) begin
    if (reset_req) begin
      rst_cnt <= 8;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign reset = (rst_cnt != 0);

endmodule

`default_nettype wire

//--- hw/board_game_pkg.sv
`default_nettype none

package board_game_pkg;

  // square coordinate, wide enough for boards up to 16 squares across
  typedef logic [3:0] coord_t;

  // piece code: bit 3 is the owner, bits 2:0 the kind
  typedef logic [3:0] piece_t;

  localparam logic [2:0] KIND_EMPTY   = 3'd0;
  localparam logic [2:0] KIND_SOLDIER = 3'd1;
  localparam logic [2:0] KIND_KING    = 3'd2;

  // board memory commands from the control FSM
  typedef enum logic [1:0] {
    MEM_IDLE = 2'd0,
    MEM_READ = 2'd1,
    MEM_MOVE = 2'd2
  } mem_op_t;

  // turn FSM states
  typedef enum logic [3:0] {
    S_INIT                 = 4'd0,
    S_MOVE_BOX_1           = 4'd1,
    S_SELECT_PIECE         = 4'd2,
    S_VALIDATE_PIECE       = 4'd3,
    S_MOVE_BOX_2           = 4'd4,
    S_SELECT_DESTINATION   = 4'd5,
    S_VALIDATE_DESTINATION = 4'd6,
    S_COMMIT_MOVE          = 4'd7,
    S_CHECK_WINNING        = 4'd8,
    S_GAME_OVER            = 4'd9
  } game_state_t;

endpackage

`default_nettype wire

//--- hw/board_game_top.sv
`default_nettype none

module board_game_top #(
  parameter int BOARD_SIZE = 8,
  parameter int PACE_DIV   = 1
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   up,
  input  logic                   down,
  input  logic                   left,
  input  logic                   right,
  input  logic                   select,
  input  logic                   deselect,
  input  board_game_pkg::coord_t view_x,
  input  board_game_pkg::coord_t view_y,
  output board_game_pkg::piece_t view_piece,
  output board_game_pkg::coord_t box_x,
  output board_game_pkg::coord_t box_y,
  output logic                   current_player,
  output logic                   game_over,
  output logic                   winner
);

  import board_game_pkg::*;

  logic    step_up;
  logic    step_down;
  logic    step_left;
  logic    step_right;
  mem_op_t mem_op;
  coord_t  src_x;
  coord_t  src_y;
  piece_t  src_piece;
  piece_t  dst_piece;
  logic    piece_ok;
  logic    move_ok;
  logic    king_taken;

  cursor_pacer #(
    .PACE_DIV (PACE_DIV)
  ) i_pacer (
    .clk        (clk),
    .reset      (reset),
    .up         (up),
    .down       (down),
    .left       (left),
    .right      (right),
    .step_up    (step_up),
    .step_down  (step_down),
    .step_left  (step_left),
    .step_right (step_right)
  );

  // the box doubles as the destination square
  game_control #(
    .BOARD_SIZE (BOARD_SIZE)
  ) i_control (
    .clk            (clk),
    .reset          (reset),
    .select         (select),
    .deselect       (deselect),
    .step_up        (step_up),
    .step_down      (step_down),
    .step_left      (step_left),
    .step_right     (step_right),
    .piece_ok       (piece_ok),
    .move_ok        (move_ok),
    .king_taken     (king_taken),
    .mem_op         (mem_op),
    .src_x          (src_x),
    .src_y          (src_y),
    .dst_x          (box_x),
    .dst_y          (box_y),
    .current_player (current_player),
    .game_over      (game_over),
    .winner         (winner)
  );

  move_checker #(
    .BOARD_SIZE (BOARD_SIZE)
  ) i_checker (
    .current_player (current_player),
    .src_x          (src_x),
    .src_y          (src_y),
    .dst_x          (box_x),
    .dst_y          (box_y),
    .src_piece      (src_piece),
    .dst_piece      (dst_piece),
    .piece_ok       (piece_ok),
    .move_ok        (move_ok),
    .king_taken     (king_taken)
  );

  board_memory #(
    .BOARD_SIZE (BOARD_SIZE)
  ) i_board (
    .clk        (clk),
    .reset      (reset),
    .mem_op     (mem_op),
    .src_x      (src_x),
    .src_y      (src_y),
    .dst_x      (box_x),
    .dst_y      (box_y),
    .view_x     (view_x),
    .view_y     (view_y),
    .src_piece  (src_piece),
    .dst_piece  (dst_piece),
    .view_piece (view_piece)
  );

endmodule

`default_nettype wire

//--- hw/board_memory.sv
`default_nettype none

module board_memory #(
  parameter int BOARD_SIZE = 8
) (
  input  logic                    clk,
  input  logic                    reset,
  input  board_game_pkg::mem_op_t mem_op,
  input  board_game_pkg::coord_t  src_x,
  input  board_game_pkg::coord_t  src_y,
  input  board_game_pkg::coord_t  dst_x,
  input  board_game_pkg::coord_t  dst_y,
  input  board_game_pkg::coord_t  view_x,
  input  board_game_pkg::coord_t  view_y,
  output board_game_pkg::piece_t  src_piece,
  output board_game_pkg::piece_t  dst_piece,
  output board_game_pkg::piece_t  view_piece
);

  import board_game_pkg::*;

  localparam int IDX_W = (BOARD_SIZE > 1) ? $clog2(BOARD_SIZE) : 1;

  // indexed as squares[x][y], row y = 0 is player 0's home row
  piece_t squares [BOARD_SIZE][BOARD_SIZE];

  logic [IDX_W-1:0] sx;
  logic [IDX_W-1:0] sy;
  logic [IDX_W-1:0] dx;
  logic [IDX_W-1:0] dy;
  logic [IDX_W-1:0] vx;
  logic [IDX_W-1:0] vy;

  assign sx = src_x[IDX_W-1:0];
  assign sy = src_y[IDX_W-1:0];
  assign dx = dst_x[IDX_W-1:0];
  assign dy = dst_y[IDX_W-1:0];
  assign vx = view_x[IDX_W-1:0];
  assign vy = view_y[IDX_W-1:0];

  // starting layout, kings in the middle of the back rows
  function automatic piece_t home_piece(int x, int y);
    piece_t p;
    p = {1'b0, KIND_EMPTY};
    if (y == 1) begin
      p = {1'b0, KIND_SOLDIER};
    end else if (y == BOARD_SIZE - 2) begin
      p = {1'b1, KIND_SOLDIER};
    end else if (y == 0 && x == BOARD_SIZE / 2) begin
      p = {1'b0, KIND_KING};
    end else if (y == BOARD_SIZE - 1 && x == BOARD_SIZE / 2) begin
      p = {1'b1, KIND_KING};
    end
    return p;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int x = 0; x < BOARD_SIZE; x++) begin
        for (int y = 0; y < BOARD_SIZE; y++) begin
          squares[x][y] <= home_piece(x, y);
        end
      end
    end else if (mem_op == MEM_MOVE) begin
      squares[dx][dy] <= src_piece;
      squares[sx][sy] <= {1'b0, KIND_EMPTY};
    end
  end

  // both squares registered for the checker
  always_ff @(posedge clk) begin
    if (mem_op == MEM_READ) begin
      src_piece <= squares[sx][sy];
      dst_piece <= squares[dx][dy];
    end
  end

  assign view_piece = squares[vx][vy];

endmodule

`default_nettype wire

//--- hw/cursor_pacer.sv
`default_nettype none

module cursor_pacer #(
  parameter int PACE_DIV = 1
) (
  input  logic clk,
  input  logic reset,
  input  logic up,
  input  logic down,
  input  logic left,
  input  logic right,
  output logic step_up,
  output logic step_down,
  output logic step_left,
  output logic step_right
);

  localparam int CNT_W = (PACE_DIV > 1) ? $clog2(PACE_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PACE_DIV - 1);

  logic [CNT_W-1:0] pace_cnt;
  logic             pace_tick;

  // tick on the last count of each pace period
  assign pace_tick = (pace_cnt == CNT_LAST);

  always_ff @(posedge clk) begin
    if (reset || pace_tick) begin
      pace_cnt <= '0;
    end else begin
      pace_cnt <= pace_cnt + 1'b1;
    end
  end

  // held buttons step once per tick
  assign step_up    = up & pace_tick;
  assign step_down  = down & pace_tick;
  assign step_left  = left & pace_tick;
  assign step_right = right & pace_tick;

endmodule

`default_nettype wire

//--- hw/game_control.sv
`default_nettype none

module game_control #(
  parameter int BOARD_SIZE = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   select,
  input  logic                   deselect,
  input  logic                   step_up,
  input  logic                   step_down,
  input  logic                   step_left,
  input  logic                   step_right,
  input  logic                   piece_ok,
  input  logic                   move_ok,
  input  logic                   king_taken,
  output board_game_pkg::mem_op_t mem_op,
  output board_game_pkg::coord_t src_x,
  output board_game_pkg::coord_t src_y,
  output board_game_pkg::coord_t dst_x,
  output board_game_pkg::coord_t dst_y,
  output logic                   current_player,
  output logic                   game_over,
  output logic                   winner
);

  import board_game_pkg::*;

  localparam coord_t BOX_MAX = coord_t'(BOARD_SIZE - 1);

  game_state_t state;
  game_state_t next_state;
  coord_t      box_x;
  coord_t      box_y;
  logic        box_active;
  logic        king_hit;

  // state table
  always_comb begin
    next_state = state;
    case (state)
      S_INIT: begin
        next_state = S_MOVE_BOX_1;
      end
      S_MOVE_BOX_1: begin
        if (select) begin
          next_state = S_SELECT_PIECE;
        end
      end
      S_SELECT_PIECE: begin
        next_state = S_VALIDATE_PIECE;
      end
      S_VALIDATE_PIECE: begin
        // hold here until select is let go
        if (!select) begin
          next_state = piece_ok ? S_MOVE_BOX_2 : S_MOVE_BOX_1;
        end
      end
      S_MOVE_BOX_2: begin
        if (deselect) begin
          if (!select) begin
            next_state = S_MOVE_BOX_1;
          end
        end else if (select) begin
          next_state = S_SELECT_DESTINATION;
        end
      end
      S_SELECT_DESTINATION: begin
        next_state = S_VALIDATE_DESTINATION;
      end
      S_VALIDATE_DESTINATION: begin
        if (!select) begin
          next_state = move_ok ? S_COMMIT_MOVE : S_MOVE_BOX_2;
        end
      end
      S_COMMIT_MOVE: begin
        next_state = S_CHECK_WINNING;
      end
      S_CHECK_WINNING: begin
        next_state = king_hit ? S_GAME_OVER : S_MOVE_BOX_1;
      end
      S_GAME_OVER: begin
        next_state = S_GAME_OVER;
      end
      default: begin
        next_state = S_INIT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_INIT;
    end else begin
      state <= next_state;
    end
  end

  // board access per state
  always_comb begin
    case (state)
      S_SELECT_PIECE, S_SELECT_DESTINATION: mem_op = MEM_READ;
      S_COMMIT_MOVE:                        mem_op = MEM_MOVE;
      default:                              mem_op = MEM_IDLE;
    endcase
  end

  assign box_active = (state == S_MOVE_BOX_1) || (state == S_MOVE_BOX_2);

  // selection box, saturating at the board edges
  always_ff @(posedge clk) begin
    if (reset) begin
      box_x <= '0;
      box_y <= '0;
    end else if (box_active) begin
      if (step_right && box_x < BOX_MAX) begin
        box_x <= box_x + 4'd1;
      end else if (step_left && box_x != '0) begin
        box_x <= box_x - 4'd1;
      end
      if (step_up && box_y < BOX_MAX) begin
        box_y <= box_y + 4'd1;
      end else if (step_down && box_y != '0) begin
        box_y <= box_y - 4'd1;
      end
    end
  end

  assign dst_x = box_x;
  assign dst_y = box_y;

  // source square captured as the piece is picked
  always_ff @(posedge clk) begin
    if (state == S_MOVE_BOX_1 && select) begin
      src_x <= box_x;
      src_y <= box_y;
    end
  end

  // turn and result registers
  always_ff @(posedge clk) begin
    if (reset) begin
      current_player <= 1'b0;
      king_hit       <= 1'b0;
      game_over      <= 1'b0;
      winner         <= 1'b0;
    end else begin
      if (state == S_COMMIT_MOVE) begin
        current_player <= ~current_player;
        king_hit       <= king_taken;
      end
      // player has already toggled, so the mover is the other one
      if (state == S_CHECK_WINNING && king_hit) begin
        game_over <= 1'b1;
        winner    <= ~current_player;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/move_checker.sv
`default_nettype none

module move_checker #(
  parameter int BOARD_SIZE = 8
) (
  input  logic                   current_player,
  input  board_game_pkg::coord_t src_x,
  input  board_game_pkg::coord_t src_y,
  input  board_game_pkg::coord_t dst_x,
  input  board_game_pkg::coord_t dst_y,
  input  board_game_pkg::piece_t src_piece,
  input  board_game_pkg::piece_t dst_piece,
  output logic                   piece_ok,
  output logic                   move_ok,
  output logic                   king_taken
);

  import board_game_pkg::*;

  localparam coord_t MAX_COORD = coord_t'(BOARD_SIZE - 1);

  coord_t dist_x;
  coord_t dist_y;
  logic   one_step;
  logic   on_board;
  logic   dst_empty;
  logic   dst_enemy;

  // source must hold one of the mover's own pieces
  assign piece_ok = (src_piece[2:0] != KIND_EMPTY) && (src_piece[3] == current_player);

  // absolute distance on each axis
  assign dist_x = (dst_x > src_x) ? (dst_x - src_x) : (src_x - dst_x);
  assign dist_y = (dst_y > src_y) ? (dst_y - src_y) : (src_y - dst_y);

  // chebyshev distance of exactly one
  assign one_step = (dist_x <= 4'd1) && (dist_y <= 4'd1) &&
                    ((dist_x != '0) || (dist_y != '0));

  assign on_board = (dst_x <= MAX_COORD) && (dst_y <= MAX_COORD);

  assign dst_empty = (dst_piece[2:0] == KIND_EMPTY);
  assign dst_enemy = !dst_empty && (dst_piece[3] != current_player);

  assign move_ok = one_step && on_board && (dst_empty || dst_enemy);

  // taking the other king decides the game
  assign king_taken = dst_enemy && (dst_piece[2:0] == KIND_KING);

endmodule

`default_nettype wire
